//--- Makefile
# Verilator build and run of the block mover testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= block_mover_tb
FILELIST  ?= block_mover.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# result decided by the pass message in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- block_mover.f
+incdir+logic
logic/mover_pkg.sv
logic/mover_ctrl.sv
logic/mover_timer.sv
logic/dram_port.sv
logic/section_buffer.sv
logic/block_mover_top.sv
verification/clock_gen.sv
verification/block_mover_tb.sv

//--- logic/block_mover_top.sv
// ----------------------------------------
// block mover, memory and section buffer
// one move at a time
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module block_mover_top (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        cmd_issue,
  input  wire mover_pkg::move_cmd_t  cmd,
  input  wire                        load,
  input  wire [`MOVER_ADDR_W-1:0]    load_addr,
  input  wire [`MOVER_WORD_W-1:0]    load_word,
  input  wire                        drain,
  input  wire [1:0]                  drain_sec,
  output mover_pkg::move_stat_t      stat,
  output logic [3:0]                 sec_full,
  output logic [`MOVER_WORD_W-1:0]   drain_word,
  output logic                       drain_valid
);

  mover_pkg::mem_req_t     mem_req;
  mover_pkg::mem_rsp_t     mem_rsp;
  mover_pkg::buf_wr_t      buf_wr;
  logic                    tim_load;
  logic                    skip_head;
  logic                    trim_tail;
  logic [`MOVER_CNT_W-1:0] reads_issued;
  logic [1:0]              cur_section;
  logic                    drain_done;
  logic                    busy;
  logic                    done;
  logic                    abrupt_stop;
  logic [`MOVER_CNT_W-1:0] count_sent;

  assign stat.busy        = busy;
  assign stat.done        = done;
  assign stat.abrupt_stop = abrupt_stop;
  assign stat.count       = count_sent;

  mover_ctrl u_ctrl (
    .CLK(CLK), .RST(RST), .cmd_issue(cmd_issue), .cmd(cmd),
    .sec_full(sec_full), .drain_done(drain_done), .mem_req(mem_req),
    .tim_load(tim_load), .skip_head(skip_head), .trim_tail(trim_tail),
    .reads_issued(reads_issued), .cur_section(cur_section),
    .abrupt_stop(abrupt_stop), .done(done), .busy(busy)
  );

  mover_timer u_timer (
    .CLK(CLK), .RST(RST), .tim_load(tim_load), .skip_head(skip_head),
    .trim_tail(trim_tail), .reads_issued(reads_issued), .section(cur_section),
    .mem_rsp(mem_rsp), .buf_wr(buf_wr), .drain_done(drain_done),
    .count_sent(count_sent)
  );

  dram_port u_dram (
    .CLK(CLK), .RST(RST), .load(load), .load_addr(load_addr),
    .load_word(load_word), .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

  section_buffer u_buf (
    .CLK(CLK), .RST(RST), .buf_wr(buf_wr), .drain(drain), .drain_sec(drain_sec),
    .drain_word(drain_word), .drain_valid(drain_valid), .sec_full(sec_full)
  );

endmodule

`default_nettype wire

//--- logic/dram_port.sv
// ----------------------------------------
// word memory, fixed read latency, no back-pressure
// a load and a read of one address in one cycle reads old data
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module dram_port (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       load,
  input  wire [`MOVER_ADDR_W-1:0]   load_addr,
  input  wire [`MOVER_WORD_W-1:0]   load_word,
  input  wire mover_pkg::mem_req_t  mem_req,
  output mover_pkg::mem_rsp_t       mem_rsp
);

  localparam int LAT   = `MOVER_MEM_LAT;
  localparam int WORDS = 1 << `MOVER_ADDR_W;

  logic [`MOVER_WORD_W-1:0] mem [0:WORDS-1];
  logic [LAT-1:0]           vld_pipe;          // one bit per stage
  logic [`MOVER_WORD_W-1:0] dat_pipe [0:LAT-1];

  // ----------------------------------------
  // host load port
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (load)
      mem[load_addr] <= load_word;
  end

  // ----------------------------------------
  // read pipeline, first stage is the array read
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    dat_pipe[0] <= mem[mem_req.addr];  // don't care when not valid
    for (int i = 1; i < LAT; i++)
      dat_pipe[i] <= dat_pipe[i-1];
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      vld_pipe <= '0;
    else
      vld_pipe <= {vld_pipe[LAT-2:0], mem_req.valid};
  end

  assign mem_rsp.valid = vld_pipe[LAT-1];  // LAT cycles after request
  assign mem_rsp.word  = dat_pipe[LAT-1];

endmodule

`default_nettype wire

//--- logic/mover_ctrl.sv
// ----------------------------------------
// accepts one move at a time, reads whole aligned pairs
// stop check only at pair ends, commands while busy are dropped
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module mover_ctrl (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         cmd_issue,
  input  wire mover_pkg::move_cmd_t   cmd,
  input  wire [3:0]                   sec_full,
  input  wire                         drain_done,
  output mover_pkg::mem_req_t         mem_req,
  output logic                        tim_load,
  output logic                        skip_head,
  output logic                        trim_tail,
  output logic [`MOVER_CNT_W-1:0]     reads_issued,
  output logic [1:0]                  cur_section,
  output logic                        abrupt_stop,
  output logic                        done,
  output logic                        busy
);

  typedef enum logic [1:0] {IDLE, READING, DRAINING} state_t;

  state_t                    state;
  logic [`MOVER_ADDR_W-1:0]  rd_addr;      // next word to read
  logic [`MOVER_CNT_W-1:0]   pairs_left;   // incl. the pair in progress
  logic                      second_word;  // odd half of a pair
  logic                      stop_seen;    // full flag cut the move
  logic [`MOVER_CNT_W:0]     pair_sum;     // count + odd + 1, one bit wider
  logic                      odd_start;
  logic                      sel_full;

  // ----------------------------------------
  // command decode
  // ----------------------------------------
  assign odd_start = cmd.addr[0];
  assign pair_sum  = {1'b0, cmd.count} + {{`MOVER_CNT_W{1'b0}}, odd_start} + 1'b1;

  assign tim_load  = cmd_issue && (state == IDLE);  // accept cycle only
  assign skip_head = odd_start;                     // word before start
  assign trim_tail = cmd.count[0] ^ odd_start;      // word after the end

  assign sel_full = sec_full[cur_section];

  assign mem_req.valid = (state == READING);  // one word per cycle
  assign mem_req.addr  = rd_addr;

  // ----------------------------------------
  // move sequencing
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state        <= IDLE;
      pairs_left   <= '0;
      second_word  <= 1'b0;
      stop_seen    <= 1'b0;
      reads_issued <= '0;
      cur_section  <= 2'd0;
      abrupt_stop  <= 1'b0;
      done         <= 1'b0;
      busy         <= 1'b0;
    end
    else
    begin
      done <= 1'b0;  // strobe
      case (state)
        IDLE:
        begin
          if (cmd_issue)
          begin
            state        <= READING;
            busy         <= 1'b1;
            rd_addr      <= {cmd.addr[`MOVER_ADDR_W-1:1], 1'b0};  // round down
            cur_section  <= cmd.section;
            pairs_left   <= pair_sum[`MOVER_CNT_W:1];             // round up
            second_word  <= 1'b0;
            stop_seen    <= 1'b0;
            reads_issued <= '0;
            abrupt_stop  <= 1'b0;
          end
        end
        READING:
        begin
          rd_addr     <= rd_addr + 1'b1;
          second_word <= !second_word;
          if (second_word)  // pair complete
          begin
            reads_issued <= reads_issued + 1'b1;
            pairs_left   <= pairs_left - 1'b1;
            if (pairs_left == 1)
              state <= DRAINING;  // all pairs read
            else if (sel_full)
            begin
              state     <= DRAINING;  // section nearly full, cut short
              stop_seen <= 1'b1;
            end
          end
        end
        DRAINING:
        begin
          if (drain_done)  // last word written this cycle
          begin
            state       <= IDLE;
            busy        <= 1'b0;
            done        <= 1'b1;
            abrupt_stop <= stop_seen;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/mover_defs.svh
// ----------------------------------------
// sizes and timing of the block mover, fixed at build time
// MOVER_MEM_LAT must be 2 or more, depth a power of two
// ----------------------------------------
`ifndef MOVER_DEFS_SVH
`define MOVER_DEFS_SVH

// ----------------------------------------
// data path
// ----------------------------------------
`define MOVER_ADDR_W      12   // word address, 4096 words
`define MOVER_WORD_W      16   // one memory word
`define MOVER_CNT_W       6    // word count, 1..63

// ----------------------------------------
// memory and buffer timing
// ----------------------------------------
`define MOVER_MEM_LAT     3    // request to returned word
`define MOVER_SEC_DEPTH   16   // words per section

// full while free places < margin
// covers read latency, flag lag and one pair
`define MOVER_FULL_MARGIN 8

`endif

//--- logic/mover_pkg.sv
// ----------------------------------------
// bus structs shared by the mover blocks
// ----------------------------------------
`default_nettype none

`include "mover_defs.svh"

package mover_pkg;

  // host command, one strobe per move
  typedef struct packed {
    logic [`MOVER_ADDR_W-1:0] addr;     // first word, any alignment
    logic [`MOVER_CNT_W-1:0]  count;    // words wanted
    logic [1:0]               section;  // target buffer section
  } move_cmd_t;

  // one word read per strobe
  typedef struct packed {
    logic                     valid;
    logic [`MOVER_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                     valid;  // word returned this cycle
    logic [`MOVER_WORD_W-1:0] word;
  } mem_rsp_t;

  typedef struct packed {
    logic                     valid;
    logic [1:0]               section;
    logic [`MOVER_WORD_W-1:0] word;
  } buf_wr_t;

  typedef struct packed {
    logic                    busy;
    logic                    done;         // single cycle
    logic                    abrupt_stop;  // valid from done on
    logic [`MOVER_CNT_W-1:0] count;        // words written to the buffer
  } move_stat_t;

endpackage

`default_nettype wire

//--- logic/mover_timer.sv
// ----------------------------------------
// filters returned words into buffer writes
// relies on in-order returns and a stable section per move
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module mover_timer (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       tim_load,
  input  wire                       skip_head,
  input  wire                       trim_tail,
  input  wire [`MOVER_CNT_W-1:0]    reads_issued,
  input  wire [1:0]                 section,
  input  wire mover_pkg::mem_rsp_t  mem_rsp,
  output mover_pkg::buf_wr_t        buf_wr,
  output logic                      drain_done,
  output logic [`MOVER_CNT_W-1:0]   count_sent
);

  logic                   skip_q;
  logic                   trim_q;
  logic [`MOVER_CNT_W:0]  rx_cnt;     // words returned so far
  logic [`MOVER_CNT_W:0]  rx_total;   // two words per issued pair
  logic                   is_first;
  logic                   is_last;
  logic                   drop;

  // while reads continue the issued pairs run ahead of the returns,
  // so is_last only fires once the controller has stopped
  assign rx_total = {reads_issued, 1'b0};
  assign is_first = (rx_cnt == '0);
  assign is_last  = (rx_cnt + 1'b1) == rx_total;
  assign drop     = (is_first && skip_q) || (is_last && trim_q);

  assign buf_wr.valid   = mem_rsp.valid && !drop;
  assign buf_wr.section = section;
  assign buf_wr.word    = mem_rsp.word;

  assign drain_done = mem_rsp.valid && is_last && (reads_issued != '0);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      skip_q     <= 1'b0;
      trim_q     <= 1'b0;
      rx_cnt     <= '0;
      count_sent <= '0;
    end
    else if (tim_load)  // new move
    begin
      skip_q     <= skip_head;
      trim_q     <= trim_tail;
      rx_cnt     <= '0;
      count_sent <= '0;
    end
    else
    begin
      if (mem_rsp.valid)
        rx_cnt <= rx_cnt + 1'b1;
      if (buf_wr.valid)
        count_sent <= count_sent + 1'b1;  // words that reached the buffer
    end
  end

endmodule

`default_nettype wire

//--- logic/section_buffer.sv
// ----------------------------------------
// four circular sections, one write and one drain per cycle
// writes to a section with no free place are lost
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module section_buffer (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire mover_pkg::buf_wr_t   buf_wr,
  input  wire                       drain,
  input  wire [1:0]                 drain_sec,
  output logic [`MOVER_WORD_W-1:0]  drain_word,
  output logic                      drain_valid,
  output logic [3:0]                sec_full
);

  localparam int PTR_W = $clog2(`MOVER_SEC_DEPTH);
  localparam int OCC_W = PTR_W + 1;

  logic [`MOVER_WORD_W-1:0] store [0:4*`MOVER_SEC_DEPTH-1];  // {section, ptr}
  logic [PTR_W-1:0]         wr_ptr [0:3];
  logic [PTR_W-1:0]         rd_ptr [0:3];
  logic [OCC_W-1:0]         occ    [0:3];  // 0..depth
  logic [3:0]               wr_hit;        // accepted write per section
  logic [3:0]               rd_hit;        // accepted drain per section

  // ----------------------------------------
  // per-section decode and status
  // ----------------------------------------
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      wr_hit[i]   = buf_wr.valid && (buf_wr.section == 2'(i))
                    && (occ[i] != OCC_W'(`MOVER_SEC_DEPTH));
      rd_hit[i]   = drain && (drain_sec == 2'(i)) && (occ[i] != '0);
      sec_full[i] = (OCC_W'(`MOVER_SEC_DEPTH) - occ[i]) < OCC_W'(`MOVER_FULL_MARGIN);
    end
  end

  // ----------------------------------------
  // storage and drain data
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (|wr_hit)
      store[{buf_wr.section, wr_ptr[buf_wr.section]}] <= buf_wr.word;
    drain_word <= store[{drain_sec, rd_ptr[drain_sec]}];  // next cycle
  end

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      drain_valid <= 1'b0;
      for (int i = 0; i < 4; i++)
      begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        occ[i]    <= '0;
      end
    end
    else
    begin
      drain_valid <= |rd_hit;  // low for an empty section
      for (int i = 0; i < 4; i++)
      begin
        if (wr_hit[i])
          wr_ptr[i] <= wr_ptr[i] + 1'b1;  // wraps at depth
        if (rd_hit[i])
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        if (wr_hit[i] && !rd_hit[i])
          occ[i] <= occ[i] + 1'b1;
        else if (!wr_hit[i] && rd_hit[i])
          occ[i] <= occ[i] - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/block_mover_tb.sv
// ----------------------------------------
// directed tests of the block mover on memory words 0..255 only
// drained words checked against a per-section model of the memory copy
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mover_defs.svh"

module block_mover_tb;

  localparam int LOAD_WORDS  = 256;   // memory region the tests use
  localparam int DONE_WAIT   = 200;   // cycles allowed for one move
  localparam int CYCLE_LIMIT = 4000;  // load 260 + tests under 800, slack

  logic                       CLK;
  logic                       RST;
  logic                       rst_req;
  logic                       cmd_issue;
  mover_pkg::move_cmd_t       cmd;
  logic                       load;
  logic [`MOVER_ADDR_W-1:0]   load_addr;
  logic [`MOVER_WORD_W-1:0]   load_word;
  logic                       drain;
  logic [1:0]                 drain_sec;
  mover_pkg::move_stat_t      stat;
  logic [3:0]                 sec_full;
  logic [`MOVER_WORD_W-1:0]   drain_word;
  logic                       drain_valid;

  logic [`MOVER_WORD_W-1:0]   mem_copy  [0:LOAD_WORDS-1];  // what was loaded
  logic [`MOVER_WORD_W-1:0]   exp_words [0:3][0:63];       // expected per section
  int                         exp_head  [0:3];
  int                         exp_tail  [0:3];
  int                         errors    = 0;
  int                         checks    = 0;
  int                         cycle_cnt = 0;

  clock_gen u_clk (.rst_req(rst_req), .CLK(CLK), .RST(RST));

  block_mover_top DUT (
    .CLK(CLK), .RST(RST), .cmd_issue(cmd_issue), .cmd(cmd),
    .load(load), .load_addr(load_addr), .load_word(load_word),
    .drain(drain), .drain_sec(drain_sec), .stat(stat), .sec_full(sec_full),
    .drain_word(drain_word), .drain_valid(drain_valid)
  );

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input logic [`MOVER_WORD_W-1:0] exp,
                            input logic [`MOVER_WORD_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_stat(input string name, input mover_pkg::move_stat_t exp,
                            input mover_pkg::move_stat_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected busy/done/abrupt %b%b%b count %0d, actual %b%b%b count %0d",
               name, exp.busy, exp.done, exp.abrupt_stop, exp.count,
               act.busy, act.done, act.abrupt_stop, act.count);
    end
  endtask

  task automatic check_count(input string name, input logic [`MOVER_CNT_W-1:0] exp,
                             input logic [`MOVER_CNT_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_full(input string name, input logic [3:0] exp, input logic [3:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s sec_full: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // stimulus and model helpers
  // ----------------------------------------
  task automatic load_memory();
    logic [`MOVER_WORD_W-1:0] w;
    for (int a = 0; a < LOAD_WORDS; a++)
    begin
      w           = `MOVER_WORD_W'($urandom);
      mem_copy[a] = w;
      @(posedge CLK);
      load      <= 1'b1;
      load_addr <= `MOVER_ADDR_W'(a);
      load_word <= w;
    end
    @(posedge CLK);
    load <= 1'b0;
  endtask

  task automatic issue_cmd(input int addr, input int count, input int sec);
    @(posedge CLK);
    cmd_issue   <= 1'b1;
    cmd.addr    <= `MOVER_ADDR_W'(addr);
    cmd.count   <= `MOVER_CNT_W'(count);
    cmd.section <= 2'(sec);
    @(posedge CLK);
    cmd_issue <= 1'b0;  // one-cycle strobe
  endtask

  task automatic wait_done(input string name, output mover_pkg::move_stat_t st);
    int waited;
    waited = 0;
    do
    begin
      @(negedge CLK);  // status settled mid-cycle
      waited++;
    end
    while (!stat.done && waited < DONE_WAIT);
    st = stat;
    if (!stat.done)
    begin
      errors++;
      $display("Error %s: done strobe did not arrive within %0d cycles", name, DONE_WAIT);
    end
  endtask

  task automatic push_expected(input int sec, input int addr, input int n);
    for (int i = 0; i < n; i++)
    begin
      exp_words[sec][exp_tail[sec] % 64] = mem_copy[addr + i];  // requested words only
      exp_tail[sec]++;
    end
  endtask

  task automatic pop_and_check(input string name, input int sec);
    @(posedge CLK);
    drain     <= 1'b1;
    drain_sec <= 2'(sec);
    @(posedge CLK);
    drain <= 1'b0;
    @(negedge CLK);  // word due one cycle after the strobe
    check_flag({name, " drain_valid"}, 1'b1, drain_valid);
    check_word({name, " drain_word"}, exp_words[sec][exp_head[sec] % 64], drain_word);
    exp_head[sec]++;
  endtask

  task automatic check_empty_drain(input string name, input int sec);
    @(posedge CLK);
    drain     <= 1'b1;
    drain_sec <= 2'(sec);
    @(posedge CLK);
    drain <= 1'b0;
    @(negedge CLK);
    check_flag({name, " empty drain_valid"}, 1'b0, drain_valid);
  endtask

  task automatic drain_section(input string name, input int sec);
    while (exp_head[sec] != exp_tail[sec])
      pop_and_check(name, sec);
    check_empty_drain(name, sec);  // nothing left over
  endtask

  task automatic run_move(input string name, input int addr, input int count, input int sec);
    mover_pkg::move_stat_t st;
    mover_pkg::move_stat_t exp;
    issue_cmd(addr, count, sec);
    wait_done(name, st);
    exp.busy        = 1'b0;  // busy drops with done
    exp.done        = 1'b1;
    exp.abrupt_stop = 1'b0;
    exp.count       = `MOVER_CNT_W'(count);
    check_stat(name, exp, st);
    push_expected(sec, addr, count);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic aligned_move();
    run_move("aligned move", 16, 8, 0);
    drain_section("aligned move", 0);
  endtask

  task automatic odd_start_moves();
    run_move("odd start count 1", 41, 1, 2);   // one pair, head dropped
    drain_section("odd start count 1", 2);
    run_move("odd start count 5", 63, 5, 2);
    drain_section("odd start count 5", 2);
    run_move("odd start count 7", 101, 7, 2);
    drain_section("odd start count 7", 2);
  endtask

  task automatic section_isolation();
    run_move("isolation section 1", 130, 6, 1);
    run_move("isolation section 3", 151, 4, 3);  // head and tail both dropped
    drain_section("isolation section 1", 1);
    drain_section("isolation section 3", 3);
  endtask

  task automatic abrupt_stop_move();
    mover_pkg::move_stat_t st;
    mover_pkg::move_stat_t exp;
    int                    n;
    int                    left;
    int                    flag_cycle;
    int                    exp_n;
    issue_cmd(160, 40, 0);  // far more than one section holds
    wait_done("abrupt stop", st);
    n = int'(st.count);
    checks++;
    if (n < 9 || n > 16)
    begin
      errors++;
      $display("Fail abrupt stop count: expected 9..16, actual %0d", n);
    end
    // flag seen once depth-margin+1 words are in, first write at cycle 1+LAT
    flag_cycle = 1 + `MOVER_MEM_LAT + `MOVER_SEC_DEPTH - `MOVER_FULL_MARGIN + 1;
    exp_n      = 2 * ((flag_cycle + 1) / 2);  // reads end with the pair in progress
    exp.busy        = 1'b0;
    exp.done        = 1'b1;
    exp.abrupt_stop = 1'b1;
    exp.count       = `MOVER_CNT_W'(exp_n);
    check_stat("abrupt stop", exp, st);
    push_expected(0, 160, n);
    left = n;
    while (left > 0)
    begin
      check_full("abrupt stop", {3'b000, (`MOVER_SEC_DEPTH - left) < `MOVER_FULL_MARGIN},
                 sec_full);
      pop_and_check("abrupt stop", 0);
      left = exp_tail[0] - exp_head[0];
    end
    check_full("abrupt stop drained", 4'b0000, sec_full);
    check_empty_drain("abrupt stop", 0);
  endtask

  task automatic issue_while_busy();
    mover_pkg::move_stat_t st;
    mover_pkg::move_stat_t exp;
    int                    extra;
    issue_cmd(210, 6, 1);
    @(negedge CLK);
    check_flag("issue while busy busy", 1'b1, stat.busy);
    issue_cmd(20, 3, 2);  // must be dropped
    wait_done("issue while busy", st);
    exp.busy        = 1'b0;
    exp.done        = 1'b1;
    exp.abrupt_stop = 1'b0;
    exp.count       = `MOVER_CNT_W'(6);
    check_stat("issue while busy", exp, st);
    extra = 0;
    repeat (40)
    begin
      @(negedge CLK);
      if (stat.done)
        extra++;  // second command must not start
    end
    check_count("issue while busy extra done", '0, `MOVER_CNT_W'(extra));
    push_expected(1, 210, 6);
    drain_section("issue while busy", 1);
    check_empty_drain("issue while busy section 2", 2);
  endtask

  task automatic reset_state();
    mover_pkg::move_stat_t st;
    mover_pkg::move_stat_t exp;
    issue_cmd(0, 40, 2);  // leaves section 2 full, count and abrupt_stop set
    wait_done("reset state fill", st);
    check_full("reset state fill", 4'b0100, sec_full);
    @(posedge CLK);
    rst_req <= 1'b1;
    @(posedge CLK);
    rst_req <= 1'b0;
    do
      @(negedge CLK);
    while (RST);  // reset taken
    do
      @(negedge CLK);
    while (!RST);  // reset released
    exp = '0;
    check_stat("reset state", exp, stat);
    check_full("reset state", 4'b0000, sec_full);
    for (int s = 0; s < 4; s++)
      check_empty_drain("reset state", s);
  endtask

  // ----------------------------------------
  // run limit
  // ----------------------------------------
  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("Run stopped: tests did not finish within %0d cycles, errors %0d",
               CYCLE_LIMIT, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    cmd_issue = 1'b0;
    cmd       = '0;
    load      = 1'b0;
    load_addr = '0;
    load_word = '0;
    drain     = 1'b0;
    drain_sec = 2'd0;
    rst_req   = 1'b0;
    for (int s = 0; s < 4; s++)
    begin
      exp_head[s] = 0;
      exp_tail[s] = 0;
    end
    void'($urandom(32'hfa8c));  // seeds the generator once
    do
      @(posedge CLK);
    while (!RST);
    load_memory();
    aligned_move();
    odd_start_moves();
    section_isolation();
    abrupt_stop_move();
    issue_while_busy();
    reset_state();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
// ----------------------------------------
// 40 ns clock, RST low for 4 cycles from time 0
// RST pulses low again for 4 cycles after rst_req
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  input  wire  rst_req,
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD = 20;  // ns
  localparam int RST_CYCLES  = 4;

  initial
  begin
    CLK = 1'b0;
    forever
      #HALF_PERIOD CLK = ~CLK;
  end

  initial
  begin
    RST = 1'b0;  // active low from the start
    forever
    begin
      repeat (RST_CYCLES) @(posedge CLK);
      RST <= 1'b1;
      do
        @(posedge CLK);
      while (!rst_req);  // wait for a new reset request
      RST <= 1'b0;
    end
  end

endmodule

`default_nettype wire
